/* source/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DCACHE_SETS 16
`define DCACHE_WAYS 2

// address split, tag + index + offset = 32
`define DCACHE_INDEX_BITS 4
`define DCACHE_TAG_BITS 26
`define DCACHE_OFFSET_BITS 2

// apb register offsets
`define DCACHE_APB_ADDR_BITS 8
`define DCACHE_REG_CONTROL 8'h00
`define DCACHE_REG_STATUS 8'h04
`define DCACHE_REG_HITS 8'h08
`define DCACHE_REG_MISSES 8'h0C

`endif

/* source/dcache_pkg.sv */
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

  typedef struct packed {
    logic [`DCACHE_TAG_BITS-1:0]    tag;
    logic [`DCACHE_INDEX_BITS-1:0]  index;
    logic [`DCACHE_OFFSET_BITS-1:0] offset;
  } dcache_addr_fields_t;

  // raw word on the bus, fields for lookup
  typedef union packed {
    logic [31:0]         raw;
    dcache_addr_fields_t fields;
  } dcache_addr_t;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_command_t;

endpackage

`default_nettype wire

/* source/dcache_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_array (
  input  logic                          clock,
  input  logic                          reset,
  input  dcache_pkg::dcache_addr_t      lookup_addr,
  output logic                          lookup_hit,
  output logic [31:0]                   lookup_data,
  output logic                          victim_valid,
  output logic                          victim_dirty,
  output dcache_pkg::dcache_addr_t      victim_addr,
  output logic [31:0]                   victim_data,
  input  logic                          write_en,
  input  dcache_pkg::dcache_addr_t      write_addr,
  input  logic [31:0]                   write_data,
  input  logic                          write_dirty,
  input  logic                          write_fill,
  input  logic [`DCACHE_INDEX_BITS-1:0] probe_index,
  input  logic                          probe_way,
  input  logic                          invalidate_en
);

  logic [`DCACHE_TAG_BITS-1:0] tag_mem [`DCACHE_SETS][`DCACHE_WAYS];
  logic [31:0]                 data_mem [`DCACHE_SETS][`DCACHE_WAYS];

  logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] valid_bits;
  logic [`DCACHE_SETS-1:0][`DCACHE_WAYS-1:0] dirty_bits;
  // way to replace next in each set
  logic [`DCACHE_SETS-1:0]                   lru;

  logic [`DCACHE_INDEX_BITS-1:0] lookup_set;
  logic [`DCACHE_INDEX_BITS-1:0] victim_set;
  logic [`DCACHE_INDEX_BITS-1:0] write_set;
  logic [`DCACHE_WAYS-1:0]       lookup_match;
  logic                          victim_way;
  logic                          write_way;

  assign lookup_set = lookup_addr.fields.index;
  assign write_set  = write_addr.fields.index;

  always_comb begin
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      lookup_match[w] = valid_bits[lookup_set][w] &&
                        (tag_mem[lookup_set][w] == lookup_addr.fields.tag);
    end
  end

  assign lookup_hit  = |lookup_match;
  assign lookup_data = lookup_match[1] ? data_mem[lookup_set][1] : data_mem[lookup_set][0];

  // probed line during a flush walk, else lru way of the looked-up set
  assign victim_set   = invalidate_en ? probe_index : lookup_set;
  assign victim_way   = invalidate_en ? probe_way : lru[lookup_set];
  assign victim_valid = valid_bits[victim_set][victim_way];
  assign victim_dirty = dirty_bits[victim_set][victim_way];
  assign victim_data  = data_mem[victim_set][victim_way];
  assign victim_addr.raw = {tag_mem[victim_set][victim_way], victim_set,
                            {`DCACHE_OFFSET_BITS{1'b0}}};

  // fill replaces the lru way, otherwise the matching way
  assign write_way = write_fill ? lru[write_set] :
                     (valid_bits[write_set][1] &&
                      (tag_mem[write_set][1] == write_addr.fields.tag));

  always_ff @(posedge clock) begin
    if (write_en) begin
      data_mem[write_set][write_way] <= write_data;
      if (write_fill) begin
        tag_mem[write_set][write_way] <= write_addr.fields.tag;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      lru        <= '0;
    end else if (invalidate_en) begin
      valid_bits[probe_index][probe_way] <= 1'b0;
      dirty_bits[probe_index][probe_way] <= 1'b0;
    end else if (write_en) begin
      valid_bits[write_set][write_way] <= 1'b1;
      // a touch with write_dirty low keeps the line's dirty bit
      if (write_fill) begin
        dirty_bits[write_set][write_way] <= write_dirty;
      end else begin
        dirty_bits[write_set][write_way] <= dirty_bits[write_set][write_way] | write_dirty;
      end
      lru[write_set] <= ~write_way;
    end
  end

endmodule

`default_nettype wire

/* source/dcache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_controller (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          req_valid,
  input  logic                          req_write,
  input  logic [31:0]                   req_addr,
  input  logic [31:0]                   req_wdata,
  output logic                          resp_valid,
  output logic [31:0]                   resp_rdata,
  output dcache_pkg::dcache_addr_t      lookup_addr,
  input  logic                          lookup_hit,
  input  logic [31:0]                   lookup_data,
  input  logic                          victim_valid,
  input  logic                          victim_dirty,
  input  dcache_pkg::dcache_addr_t      victim_addr,
  input  logic [31:0]                   victim_data,
  output logic                          write_en,
  output dcache_pkg::dcache_addr_t      write_addr,
  output logic [31:0]                   write_data,
  output logic                          write_dirty,
  output logic                          write_fill,
  output logic [`DCACHE_INDEX_BITS-1:0] probe_index,
  output logic                          probe_way,
  output logic                          invalidate_en,
  output dcache_pkg::mem_command_t      mem_command,
  output logic [31:0]                   mem_addr,
  output logic [31:0]                   mem_wdata,
  input  logic [3:0]                    mem_response,
  input  logic [31:0]                   mem_data,
  input  logic [3:0]                    mem_tag,
  input  logic                          flush_start,
  output logic                          flush_busy,
  output logic                          hit_pulse,
  output logic                          miss_pulse
);

  localparam int FLUSH_BITS = $clog2(`DCACHE_SETS * `DCACHE_WAYS);

  localparam logic [2:0] ST_IDLE      = 3'd0;
  localparam logic [2:0] ST_WRITEBACK = 3'd1;
  localparam logic [2:0] ST_LOAD_REQ  = 3'd2;
  localparam logic [2:0] ST_LOAD_WAIT = 3'd3;
  localparam logic [2:0] ST_FILL      = 3'd4;
  localparam logic [2:0] ST_STORE     = 3'd5;
  localparam logic [2:0] ST_FLUSH     = 3'd6;

  logic [2:0]            state, next_state;
  logic [FLUSH_BITS-1:0] flush_count;
  logic                  flush_active, flush_pending, req_hit_q;
  logic                  req_write_q;
  logic [31:0]           req_wdata_q, wb_data_q, fill_data_q;
  logic [3:0]            mem_tag_q;
  dcache_pkg::dcache_addr_t req_addr_q, wb_addr_q;

  // line walk order is set-major, way in the low bit
  assign probe_index = flush_count[FLUSH_BITS-1:1];
  assign probe_way   = flush_count[0];
  assign flush_busy  = flush_active;

  always_comb begin
    next_state    = state;
    resp_valid    = 1'b0;
    resp_rdata    = '0;
    lookup_addr   = req_addr_q;
    write_en      = 1'b0;
    write_addr    = req_addr_q;
    write_data    = req_wdata_q;
    write_dirty   = 1'b0;
    write_fill    = 1'b0;
    invalidate_en = 1'b0;
    mem_command   = dcache_pkg::MEM_NONE;
    mem_addr      = '0;
    mem_wdata     = '0;
    hit_pulse     = 1'b0;
    miss_pulse    = 1'b0;
    case (state)
      ST_IDLE: begin
        lookup_addr.raw = req_addr;
        if (flush_start || flush_pending) begin
          next_state = ST_FLUSH;
        end else if (req_valid && lookup_hit && !req_write) begin
          // answer now, and touch the line for lru
          resp_valid     = 1'b1;
          resp_rdata     = lookup_data;
          hit_pulse      = 1'b1;
          write_en       = 1'b1;
          write_addr.raw = req_addr;
          write_data     = lookup_data;
        end else if (req_valid && lookup_hit) begin
          next_state = ST_STORE;
        end else if (req_valid) begin
          miss_pulse = 1'b1;
          next_state = (victim_valid && victim_dirty) ? ST_WRITEBACK : ST_LOAD_REQ;
        end
      end
      ST_WRITEBACK: begin
        mem_command = dcache_pkg::MEM_STORE;
        mem_addr    = wb_addr_q.raw;
        mem_wdata   = wb_data_q;
        if (mem_response != '0) begin
          if (!flush_active) begin
            next_state = ST_LOAD_REQ;
          end else begin
            // counter has already wrapped after the last line
            next_state = (flush_count == '0) ? ST_IDLE : ST_FLUSH;
          end
        end
      end
      ST_LOAD_REQ: begin
        mem_command = dcache_pkg::MEM_LOAD;
        mem_addr    = {req_addr_q.fields.tag, req_addr_q.fields.index,
                       {`DCACHE_OFFSET_BITS{1'b0}}};
        if (mem_response != '0) begin
          next_state = ST_LOAD_WAIT;
        end
      end
      ST_LOAD_WAIT: begin
        if (mem_tag == mem_tag_q) begin
          next_state = ST_FILL;
        end
      end
      ST_FILL: begin
        write_en   = 1'b1;
        write_fill = 1'b1;
        write_data = fill_data_q;
        if (req_write_q) begin
          next_state = ST_STORE;
        end else begin
          resp_valid = 1'b1;
          resp_rdata = fill_data_q;
          next_state = ST_IDLE;
        end
      end
      ST_STORE: begin
        write_en    = 1'b1;
        write_dirty = 1'b1;
        resp_valid  = 1'b1;
        hit_pulse   = req_hit_q;
        next_state  = ST_IDLE;
      end
      ST_FLUSH: begin
        invalidate_en = 1'b1;
        if (victim_valid && victim_dirty) begin
          next_state = ST_WRITEBACK;
        end else if (flush_count == '1) begin
          next_state = ST_IDLE;
        end
      end
      default: next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= ST_IDLE;
      flush_count   <= '0;
      flush_active  <= 1'b0;
      flush_pending <= 1'b0;
      req_hit_q     <= 1'b0;
    end else begin
      state <= next_state;
      if (state == ST_FLUSH) begin
        flush_count <= flush_count + 1'b1;
      end
      if (state == ST_IDLE) begin
        flush_active <= flush_start || flush_pending;
        req_hit_q    <= lookup_hit;
      end else if (next_state == ST_IDLE) begin
        flush_active <= 1'b0;
      end
      // a flush asked for mid-miss waits for idle
      if (state == ST_IDLE) begin
        flush_pending <= 1'b0;
      end else if (flush_start && !flush_active) begin
        flush_pending <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == ST_IDLE) begin
      req_addr_q.raw <= req_addr;
      req_wdata_q    <= req_wdata;
      req_write_q    <= req_write;
    end
    if (state == ST_IDLE || state == ST_FLUSH) begin
      wb_addr_q <= victim_addr;
      wb_data_q <= victim_data;
    end
    if (state == ST_LOAD_REQ) begin
      mem_tag_q <= mem_response;
    end
    if (state == ST_LOAD_WAIT && mem_tag == mem_tag_q) begin
      fill_data_q <= mem_data;
    end
  end

endmodule

`default_nettype wire

/* source/dcache_csr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_csr (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [`DCACHE_APB_ADDR_BITS-1:0] paddr,
  input  logic [31:0]                      pwdata,
  output logic [31:0]                      prdata,
  output logic                             pready,
  output logic                             pslverr,
  input  logic                             flush_busy,
  input  logic                             hit_pulse,
  input  logic                             miss_pulse,
  output logic                             flush_start
);

  logic [31:0] hit_count;
  logic [31:0] miss_count;
  logic        reg_mapped;
  logic        access;

  assign access = psel && penable;
  assign pready = 1'b1;

  always_comb begin
    reg_mapped = 1'b1;
    prdata     = '0;
    case (paddr)
      `DCACHE_REG_CONTROL: prdata = '0;
      `DCACHE_REG_STATUS:  prdata = {31'd0, flush_busy};
      `DCACHE_REG_HITS:    prdata = hit_count;
      `DCACHE_REG_MISSES:  prdata = miss_count;
      default:             reg_mapped = 1'b0;
    endcase
  end

  assign pslverr = access && !reg_mapped;

  always_ff @(posedge clock) begin
    if (reset) begin
      hit_count   <= '0;
      miss_count  <= '0;
      flush_start <= 1'b0;
    end else begin
      // one-cycle pulse on a control write with bit 0 set
      flush_start <= access && pwrite && (paddr == `DCACHE_REG_CONTROL) && pwdata[0];
      // counters stick at all ones
      if (hit_pulse && hit_count != '1) begin
        hit_count <= hit_count + 1'b1;
      end
      if (miss_pulse && miss_count != '1) begin
        miss_count <= miss_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             req_valid,
  input  logic                             req_write,
  input  logic [31:0]                      req_addr,
  input  logic [31:0]                      req_wdata,
  output logic                             resp_valid,
  output logic [31:0]                      resp_rdata,
  output dcache_pkg::mem_command_t         mem_command,
  output logic [31:0]                      mem_addr,
  output logic [31:0]                      mem_wdata,
  input  logic [3:0]                       mem_response,
  input  logic [31:0]                      mem_data,
  input  logic [3:0]                       mem_tag,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [`DCACHE_APB_ADDR_BITS-1:0] paddr,
  input  logic [31:0]                      pwdata,
  output logic [31:0]                      prdata,
  output logic                             pready,
  output logic                             pslverr
);

  // controller to array
  dcache_pkg::dcache_addr_t      lookup_addr, victim_addr, write_addr;
  logic                          lookup_hit, victim_valid, victim_dirty;
  logic [31:0]                   lookup_data, victim_data, write_data;
  logic                          write_en, write_dirty, write_fill;
  logic [`DCACHE_INDEX_BITS-1:0] probe_index;
  logic                          probe_way, invalidate_en;

  // controller to register block
  logic flush_start, flush_busy, hit_pulse, miss_pulse;

  dcache_array u_array (.*);

  dcache_controller u_controller (.*);

  dcache_csr u_csr (.*);

endmodule

`default_nettype wire

/* sim/dcache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
  input logic                     clock,
  input logic                     reset,
  input logic                     req_valid,
  input logic                     resp_valid,
  input dcache_pkg::mem_command_t mem_command,
  input logic [3:0]               mem_response,
  input logic                     flush_busy
);

  // a command stays put until memory answers with a nonzero response
  command_held: assert property (@(posedge clock) disable iff (reset)
    (mem_command != dcache_pkg::MEM_NONE && mem_response == 4'd0)
      |=> mem_command == $past(mem_command))
    else $error("memory command changed before it was accepted");

  response_needs_request: assert property (@(posedge clock) disable iff (reset)
    resp_valid |-> req_valid)
    else $error("response given without a pending request");

  no_response_in_flush: assert property (@(posedge clock) disable iff (reset)
    flush_busy |-> !resp_valid)
    else $error("response given while a flush is running");

endmodule

`default_nettype wire

/* sim/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb;

  localparam int NUM_RANDOM = 300;
  localparam int WORDS = 64;
  localparam int LINES = `DCACHE_SETS * `DCACHE_WAYS;
  localparam int LIMIT_CYCLES = (NUM_RANDOM + WORDS + 6) * 40 + LINES * 30 + 400;

  logic                     clock, reset;
  logic                     req_valid, req_write;
  logic [31:0]              req_addr, req_wdata;
  logic                     resp_valid;
  logic [31:0]              resp_rdata;
  dcache_pkg::mem_command_t mem_command;
  logic [31:0]              mem_addr, mem_wdata, mem_data;
  logic [3:0]               mem_response, mem_tag;
  logic                     psel, penable, pwrite, pready, pslverr;
  logic [7:0]               paddr;
  logic [31:0]              pwdata, prdata;

  // responder memory, and the model's view of memory
  logic [31:0] memory [logic [31:0]];
  logic [31:0] model_mem [logic [31:0]];
  bit          touched [logic [31:0]];

  // tag model, lru holds the way to replace next
  logic [`DCACHE_TAG_BITS-1:0] model_tag [`DCACHE_SETS][`DCACHE_WAYS];
  logic                        model_valid [`DCACHE_SETS][`DCACHE_WAYS];
  logic                        model_lru [`DCACHE_SETS];

  int          expected_hits, expected_misses;
  int          errors, checks, tests_run, tests_failed, store_count;
  logic [31:0] last_store_addr, last_store_data;

  dcache_top dut (.*);

  bind dcache_controller dcache_assertions u_assertions (
    .clock(clock), .reset(reset), .req_valid(req_valid), .resp_valid(resp_valid),
    .mem_command(mem_command), .mem_response(mem_response), .flush_busy(flush_busy)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // contents of a word that was never written
  function automatic logic [31:0] initial_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'ha5c3_3c5a;
  endfunction

  function automatic logic [31:0] read_memory(input logic [31:0] addr);
    return memory.exists(addr) ? memory[addr] : initial_word(addr);
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    return model_mem.exists(addr) ? model_mem[addr] : initial_word(addr);
  endfunction

  // predicts hit or miss and updates the 2-way lru model, write-allocate
  function automatic bit model_lookup(input logic [31:0] addr);
    logic [`DCACHE_INDEX_BITS-1:0] set;
    logic [`DCACHE_TAG_BITS-1:0]   tag;
    int                            way;
    bit                            hit;
    set = addr[`DCACHE_OFFSET_BITS +: `DCACHE_INDEX_BITS];
    tag = addr[31 -: `DCACHE_TAG_BITS];
    hit = 1'b0;
    way = int'(model_lru[set]);
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      if (model_valid[set][w] && model_tag[set][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    model_valid[set][way] = 1'b1;
    model_tag[set][way]   = tag;
    model_lru[set]        = (way == 0);
    return hit;
  endfunction

  function automatic void model_invalidate();
    for (int s = 0; s < `DCACHE_SETS; s++) begin
      model_lru[s] = 1'b0;
      for (int w = 0; w < `DCACHE_WAYS; w++) begin
        model_valid[s][w] = 1'b0;
      end
    end
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, expected);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before) begin
      tests_failed++;
    end
    $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
  endtask

  // one processor request, held until resp_valid is seen before a rising edge
  task automatic cache_access(input bit write, input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] got;
    bit          hit;
    hit = model_lookup(addr);
    if (hit) begin
      expected_hits++;
    end else begin
      expected_misses++;
    end
    touched[addr] = 1'b1;
    @(negedge clock);
    req_valid = 1'b1;
    req_write = write;
    req_addr  = addr;
    req_wdata = data;
    #1;
    while (!resp_valid) begin
      @(negedge clock);
      #1;
    end
    got = resp_rdata;
    @(negedge clock);
    req_valid = 1'b0;
    if (write) begin
      model_mem[addr] = data;
    end else begin
      check_word($sformatf("load 0x%08h", addr), got, model_read(addr));
    end
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clock);
    penable = 1'b1;
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge clock);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clock);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    check_word("pready in access phase", {31'd0, pready}, 32'd1);
    @(negedge clock);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // memory side: accepts after 0 to 3 cycles, load data 1 to 4 cycles later
  initial begin
    int          cmd_delay;
    int          data_wait;
    bit          load_pending;
    logic [3:0]  next_tag;
    logic [3:0]  load_tag;
    logic [31:0] load_addr;
    mem_response = 4'd0;
    mem_tag      = 4'd0;
    mem_data     = 32'd0;
    cmd_delay    = -1;
    data_wait    = 0;
    load_pending = 1'b0;
    next_tag     = 4'd1;
    forever begin
      @(negedge clock);
      mem_response = 4'd0;
      mem_tag      = 4'd0;
      if (load_pending) begin
        data_wait--;
        if (data_wait == 0) begin
          mem_tag      = load_tag;
          mem_data     = read_memory(load_addr);
          load_pending = 1'b0;
        end
      end
      if (reset || mem_command == dcache_pkg::MEM_NONE) begin
        cmd_delay = -1;
      end else begin
        if (cmd_delay < 0) begin
          cmd_delay = int'($urandom % 4);
        end
        if (cmd_delay == 0) begin
          mem_response = next_tag;
          cmd_delay    = -1;
          if (mem_command == dcache_pkg::MEM_LOAD) begin
            load_pending = 1'b1;
            load_tag     = next_tag;
            load_addr    = mem_addr;
            data_wait    = 1 + int'($urandom % 4);
          end else begin
            memory[mem_addr] = mem_wdata;
            last_store_addr  = mem_addr;
            last_store_data  = mem_wdata;
            store_count++;
          end
          next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end else begin
          cmd_delay--;
        end
      end
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clock);
    $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rdata, data, hits_before, misses_before, victim_data;
    logic [31:0] addr_list [$];
    logic [5:0]  word;
    logic        err;
    bit          write;
    int          start, stores_before;
    void'($urandom(32'h0f93_b4f0));
    reset     = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = 32'd0;
    req_wdata = 32'd0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = 8'd0;
    pwdata    = 32'd0;
    model_invalidate();
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    start = errors;
    apb_read(`DCACHE_REG_STATUS, rdata, err);
    check_word("status after reset", rdata, 32'd0);
    check_word("pslverr on status", {31'd0, err}, 32'd0);
    apb_read(`DCACHE_REG_HITS, rdata, err);
    check_word("hits after reset", rdata, 32'd0);
    apb_read(`DCACHE_REG_MISSES, rdata, err);
    check_word("misses after reset", rdata, 32'd0);
    apb_read(8'h10, rdata, err);
    check_word("pslverr on unmapped offset 0x10", {31'd0, err}, 32'd1);
    finish_test("reset registers and unmapped offset", start);

    start = errors;
    repeat (NUM_RANDOM) begin
      word  = 6'($urandom);
      write = 1'($urandom);
      data  = $urandom;
      cache_access(write, 32'h0000_1000 + {24'd0, word, 2'b00}, data);
    end
    finish_test("random loads and stores", start);

    start = errors;
    apb_read(`DCACHE_REG_HITS, rdata, err);
    check_word("hit counter", rdata, 32'(expected_hits));
    apb_read(`DCACHE_REG_MISSES, rdata, err);
    check_word("miss counter", rdata, 32'(expected_misses));
    finish_test("hit and miss counters", start);

    // three tags in set 5, the third evicts the first
    start       = errors;
    victim_data = $urandom;
    cache_access(1'b1, 32'h8000_0014, victim_data);
    cache_access(1'b1, 32'h8001_0014, $urandom);
    stores_before = store_count;
    cache_access(1'b1, 32'h8002_0014, $urandom);
    checks++;
    if (store_count == stores_before) begin
      errors++;
      $display("third conflicting store caused no write-back");
    end
    check_word("evicted address", last_store_addr, 32'h8000_0014);
    check_word("evicted data", last_store_data, victim_data);
    finish_test("lru eviction write-back", start);

    start = errors;
    apb_write(`DCACHE_REG_CONTROL, 32'd1);
    apb_read(`DCACHE_REG_STATUS, rdata, err);
    check_word("status busy bit", {31'd0, rdata[0]}, 32'd1);
    while (rdata[0]) begin
      apb_read(`DCACHE_REG_STATUS, rdata, err);
    end
    model_invalidate();
    foreach (touched[a]) begin
      addr_list.push_back(a);
    end
    foreach (addr_list[i]) begin
      check_word($sformatf("memory 0x%08h after flush", addr_list[i]),
                 read_memory(addr_list[i]), model_read(addr_list[i]));
    end
    apb_read(`DCACHE_REG_HITS, hits_before, err);
    apb_read(`DCACHE_REG_MISSES, misses_before, err);
    foreach (addr_list[i]) begin
      cache_access(1'b0, addr_list[i], 32'd0);
    end
    apb_read(`DCACHE_REG_HITS, rdata, err);
    check_word("hits after flush", rdata, hits_before);
    apb_read(`DCACHE_REG_MISSES, rdata, err);
    check_word("misses after flush", rdata, misses_before + 32'(addr_list.size()));
    finish_test("flush write-back and invalidate", start);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dcache.f */
+incdir+source
source/dcache_pkg.sv
source/dcache_array.sv
source/dcache_controller.sv
source/dcache_csr.sv
source/dcache_top.sv
sim/dcache_assertions.sv
sim/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcache_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FILE_LIST := dcache.f
SOURCES   := $(wildcard source/*.sv source/*.svh sim/*.sv)
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
